//--- src/fifo_pkg.sv
package fifo_pkg;

   // output stream granularity.
   localparam int slice_w         = 5;
   localparam int slices_per_word = 9;

   // a pushed word is exactly a whole number of slices.
   localparam int word_w          = slice_w * slices_per_word;

   // one stored word, slice k sits in bits 5k+4 down to 5k.
   typedef logic [word_w-1:0] word_t;

   // one slice as seen on the pop side.
   typedef logic [slice_w-1:0] slice_t;

   // unpacker states.
   // up_empty holds no word and requests one,
   // up_fetch has the memory read in flight,
   // up_emit walks the held word slice by slice.
   typedef enum logic [1:0] {
      up_empty,
      up_fetch,
      up_emit
   } unpack_state_t;

endpackage

//--- src/word_ram.sv
`timescale 1ns/1ps

module word_ram #(
   parameter  int depth  = 1024,
   localparam int addr_w = $clog2(depth)
) (
   input  logic              clk,
   input  logic              wr_en,
   input  logic [addr_w-1:0] wr_addr,
   input  fifo_pkg::word_t   wr_data,
   input  logic              rd_en,
   input  logic [addr_w-1:0] rd_addr,
   output fifo_pkg::word_t   rd_data
);

   import fifo_pkg::*;

   word_t mem [depth];   // word storage.

   // write port.
   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[wr_addr] <= wr_data;
      end
   end

   // registered read, data holds between reads.
   always_ff @(posedge clk)
   begin
      if (rd_en)
      begin
         rd_data <= mem[rd_addr];
      end
   end

endmodule

//--- src/wide_fifo_ctrl.sv
`timescale 1ns/1ps

module wide_fifo_ctrl #(
   parameter  int depth  = 1024,
   localparam int addr_w = $clog2(depth)
) (
   input  logic              clk,
   input  logic              reset,
   // push side.
   input  logic              push_valid,
   input  fifo_pkg::word_t   push_data,
   output logic              push_ready,
   // unpacker fetch handshake.
   input  logic              fetch_req,
   output logic              fetch_grant,
   // memory write port.
   output logic              wr_en,
   output logic [addr_w-1:0] wr_addr,
   output fifo_pkg::word_t   wr_data,
   // memory read port.
   output logic              rd_en,
   output logic [addr_w-1:0] rd_addr
);

   import fifo_pkg::*;

   // count value that means full.
   localparam logic [addr_w:0] full_count = (addr_w+1)'(depth);

   logic [addr_w-1:0] wr_ptr;
   logic [addr_w-1:0] rd_ptr;
   logic [addr_w:0]   count;     // one bit wider so depth fits.
   logic              full;
   logic              empty;
   logic              accept;    // push taken this cycle.

   assign full  = (count == full_count);
   assign empty = (count == '0);

   assign push_ready = !full;
   assign accept     = push_valid && push_ready;

   // a fetch is only granted when a word is stored.
   assign fetch_grant = fetch_req && !empty;

   // memory side follows the handshakes in the same cycle.
   assign wr_en   = accept;
   assign wr_addr = wr_ptr;
   assign wr_data = push_data;
   assign rd_en   = fetch_grant;
   assign rd_addr = rd_ptr;

   // write pointer, wraps at depth.
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
      end
      else if (accept)
      begin
         wr_ptr <= wr_ptr + 1'b1;
      end
   end

   // read pointer moves on every grant.
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         rd_ptr <= '0;
      end
      else if (fetch_grant)
      begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // occupancy.
   // push and grant together leave it unchanged.
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         count <= '0;
      end
      else
      begin
         case ({accept, fetch_grant})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   a_count_bound: assert property (@(posedge clk) disable iff (reset)
      count <= full_count)
      else $error("fifo count above depth");

   // equal pointers mean empty or full, the count must say which.
   // grant while empty would hand out a stale word.
   a_no_grant_empty: assert property (@(posedge clk) disable iff (reset)
      fetch_grant && (rd_ptr == wr_ptr) |-> full)
      else $error("fetch granted while empty");

   a_no_write_full: assert property (@(posedge clk) disable iff (reset)
      wr_en && (wr_ptr == rd_ptr) |-> empty)
      else $error("write while full");

endmodule

//--- src/slice_unpacker.sv
`timescale 1ns/1ps

module slice_unpacker (
   input  logic             clk,
   input  logic             reset,
   output logic             fetch_req,
   input  logic             fetch_grant,
   input  fifo_pkg::word_t  rd_data,
   output logic             out_valid,
   output fifo_pkg::slice_t out_slice,
   input  logic             out_ready
);

   import fifo_pkg::*;

   localparam int               idx_w    = $clog2(slices_per_word);
   localparam logic [idx_w-1:0] last_idx = idx_w'(slices_per_word - 1);

   unpack_state_t    state;
   logic [idx_w-1:0] idx;        // slice being offered.
   word_t            held_word;
   word_t            cur_word;
   logic             take;       // slice accepted this cycle.
   logic             last;

   // in up_fetch the word is still on the memory output.
   assign cur_word  = (state == up_fetch) ? rd_data : held_word;
   assign out_slice = cur_word[idx*slice_w +: slice_w];
   assign out_valid = (state != up_empty);

   assign take = out_valid && out_ready;
   assign last = (idx == last_idx);

   // ask for the next word early so it follows without a gap.
   assign fetch_req = (state == up_empty) || (last && take);

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state <= up_empty;
         idx   <= '0;
      end
      else
      begin
         case (state)
            up_empty:
            begin
               if (fetch_grant)
                  state <= up_fetch;
            end
            up_fetch:
            begin
               state <= up_emit;
               if (take)
                  idx <= idx + 1'b1;
            end
            default:
            begin
               if (take && last)
               begin
                  idx   <= '0;
                  state <= fetch_grant ? up_fetch : up_empty;
               end
               else if (take)
                  idx <= idx + 1'b1;
            end
         endcase
      end
   end

   // payload register, loaded once per fetched word.
   always_ff @(posedge clk)
   begin
      if (state == up_fetch)
      begin
         held_word <= rd_data;
      end
   end

   a_stall_stable: assert property (@(posedge clk) disable iff (reset)
      out_valid && !out_ready |=> out_valid && $stable(out_slice))
      else $error("slice changed under back-pressure");

   a_idx_range: assert property (@(posedge clk) disable iff (reset)
      idx <= last_idx)
      else $error("slice index out of range");

endmodule

//--- src/fifo_45to5.sv
`timescale 1ns/1ps

module fifo_45to5 #(
   parameter int depth = 1024    // words, power of two.
) (
   input  logic             clk,
   input  logic             reset,
   // push side, one 45-bit word per handshake.
   input  logic             push_valid,
   input  fifo_pkg::word_t  push_data,
   output logic             push_ready,
   // pop side, one 5-bit slice per handshake.
   output logic             out_valid,
   output fifo_pkg::slice_t out_slice,
   input  logic             out_ready
);

   import fifo_pkg::*;

   localparam int addr_w = $clog2(depth);

   logic              wr_en;
   logic [addr_w-1:0] wr_addr;
   word_t             wr_data;
   logic              rd_en;
   logic [addr_w-1:0] rd_addr;
   word_t             rd_data;
   logic              fetch_req;
   logic              fetch_grant;

   wide_fifo_ctrl #(.depth(depth)) i_wide_fifo_ctrl (
      .clk         (clk),
      .reset       (reset),
      .push_valid  (push_valid),
      .push_data   (push_data),
      .push_ready  (push_ready),
      .fetch_req   (fetch_req),
      .fetch_grant (fetch_grant),
      .wr_en       (wr_en),
      .wr_addr     (wr_addr),
      .wr_data     (wr_data),
      .rd_en       (rd_en),
      .rd_addr     (rd_addr)
   );

   word_ram #(.depth(depth)) i_word_ram (
      .clk     (clk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   // rd_data is valid the cycle after a grant.
   slice_unpacker i_slice_unpacker (
      .clk         (clk),
      .reset       (reset),
      .fetch_req   (fetch_req),
      .fetch_grant (fetch_grant),
      .rd_data     (rd_data),
      .out_valid   (out_valid),
      .out_slice   (out_slice),
      .out_ready   (out_ready)
   );

endmodule

//--- sim/tb_fifo_45to5.sv
`timescale 1ns/1ps

module tb_fifo_45to5;

   import fifo_pkg::*;

   localparam int tb_depth       = 16;
   localparam int random_words   = 40;
   localparam int stream_words   = 24;
   localparam int planned_slices =
      slices_per_word * (1 + (tb_depth + 1) + random_words + stream_words + 1);
   localparam int cycle_limit    = 2 * planned_slices * 2 + 200;
   localparam logic [31:0] lfsr_taps = 32'h80200003;

   logic        clk;
   logic        reset;
   logic        push_valid;
   word_t       push_data;
   logic        push_ready;
   logic        out_valid;
   slice_t      out_slice;
   logic        out_ready;

   logic [31:0] lfsr_state      = 32'hc22d;
   word_t       exp_q[$];             // accepted words, head is draining.
   int          slice_idx       = 0;  // next slice of the head word.
   int          pushes_accepted = 0;
   int          slices_taken    = 0;
   int          errors          = 0;
   int          errors_at_start = 0;
   int          tests_passed    = 0;
   int          tests_failed    = 0;
   int          cycles          = 0;
   string       cur_test        = "none";

   fifo_45to5 #(.depth(tb_depth)) i_fifo_45to5 (
      .clk        (clk),
      .reset      (reset),
      .push_valid (push_valid),
      .push_data  (push_data),
      .push_ready (push_ready),
      .out_valid  (out_valid),
      .out_slice  (out_slice),
      .out_ready  (out_ready)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // galois lfsr, one step per bit taken.
   function automatic logic rand_bit();
      logic b;
      b = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b)
         lfsr_state = lfsr_state ^ lfsr_taps;
      return b;
   endfunction

   function automatic word_t rand_word();
      word_t w;
      w = '0;
      for (int b = 0; b < word_w; b++)
         w = {w[word_w-2:0], rand_bit()};
      return w;
   endfunction

   // slice k of a word is bits 5k+4 down to 5k.
   function automatic slice_t ref_slice(word_t w, int k);
      return slice_t'(w >> (k * slice_w));
   endfunction

   task automatic report_mismatch(string what, logic [63:0] expected, logic [63:0] actual);
      $display("FAIL %s: %s expected %0h actual %0h", cur_test, what, expected, actual);
      errors = errors + 1;
   endtask

   task automatic report_error(string what);
      $display("error in %s: %s", cur_test, what);
      errors = errors + 1;
   endtask

   task automatic step_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic wait_slices(int target);
      while (slices_taken < target)
         step_cycle();
   endtask

   task automatic start_test(string name);
      cur_test        = name;
      errors_at_start = errors;
   endtask

   task automatic end_test();
      if (exp_q.size() != 0 || slice_idx != 0)
         report_error("words left undrained in the reference queue");
      if (errors == errors_at_start)
      begin
         tests_passed = tests_passed + 1;
         $display("test %s ok", cur_test);
      end
      else
      begin
         tests_failed = tests_failed + 1;
         $display("test %s failed, %0d errors", cur_test, errors - errors_at_start);
      end
   endtask

   // compare each taken slice against the queue head, mid cycle where all is stable.
   always @(negedge clk)
   begin : compare
      slice_t expected;
      if (!reset)
      begin
         if (out_valid && out_ready)
         begin
            if (exp_q.size() == 0)
               report_error("slice taken with no word pending");
            else
            begin
               expected = ref_slice(exp_q[0], slice_idx);
               if (out_slice !== expected)
                  report_mismatch($sformatf("slice %0d", slice_idx),
                                  64'(expected), 64'(out_slice));
               slice_idx = slice_idx + 1;
               if (slice_idx == slices_per_word)
               begin
                  slice_idx = 0;
                  void'(exp_q.pop_front());
               end
            end
            slices_taken = slices_taken + 1;
         end
         if (push_valid && push_ready)
         begin
            exp_q.push_back(push_data);
            pushes_accepted = pushes_accepted + 1;
         end
      end
   end

   initial
   begin : watchdog
      while (cycles < cycle_limit)
      begin
         @(posedge clk);
         cycles = cycles + 1;
      end
      $display("timeout after %0d cycles in test %s", cycles, cur_test);
      $display(">>> FAIL");
      $finish;
   end

   initial
   begin : main_seq
      int base_slices;
      int base_pushes;
      int prev;
      reset      = 1'b1;
      push_valid = 1'b0;
      push_data  = '0;
      out_ready  = 1'b0;
      repeat (10) @(posedge clk);
      #1 reset = 1'b0;

      start_test("reset_state");
      @(negedge clk);
      if (out_valid !== 1'b0)
         report_mismatch("out_valid", 64'(1'b0), 64'(out_valid));
      if (push_ready !== 1'b1)
         report_mismatch("push_ready", 64'(1'b1), 64'(push_ready));
      step_cycle();
      end_test();

      start_test("order_slicing");
      base_slices = slices_taken;
      out_ready   = 1'b1;
      push_valid  = 1'b1;
      push_data   = rand_word();
      step_cycle();
      push_valid  = 1'b0;
      wait_slices(base_slices + slices_per_word);
      repeat (4) step_cycle();
      if (slices_taken - base_slices != slices_per_word)
         report_mismatch("slice count", 64'(slices_per_word), 64'(slices_taken - base_slices));
      end_test();

      // the unpacker pulls one word before stalling, so full holds depth plus one.
      start_test("full");
      base_slices = slices_taken;
      base_pushes = pushes_accepted;
      out_ready   = 1'b0;
      push_valid  = 1'b1;
      push_data   = rand_word();
      repeat (2 * tb_depth)
      begin
         prev = pushes_accepted;
         step_cycle();
         if (pushes_accepted != prev)
            push_data = rand_word();
      end
      push_valid = 1'b0;
      if (pushes_accepted - base_pushes != tb_depth + 1)
         report_mismatch("accepted pushes", 64'(tb_depth + 1),
                         64'(pushes_accepted - base_pushes));
      if (push_ready !== 1'b0)
         report_mismatch("push_ready at full", 64'(1'b0), 64'(push_ready));
      out_ready = 1'b1;
      wait_slices(base_slices + (tb_depth + 1) * slices_per_word);
      end_test();

      start_test("random_backpressure");
      base_slices = slices_taken;
      base_pushes = pushes_accepted;
      prev        = pushes_accepted;
      while (pushes_accepted - base_pushes < random_words)
      begin
         // new word only once the previous one is taken.
         if (!push_valid || pushes_accepted != prev)
         begin
            push_valid = rand_bit();
            if (push_valid)
               push_data = rand_word();
         end
         prev      = pushes_accepted;
         out_ready = rand_bit();
         step_cycle();
      end
      push_valid = 1'b0;
      out_ready  = 1'b1;
      wait_slices(base_slices + random_words * slices_per_word);
      end_test();

      // one word per nine cycles matches the drain rate.
      start_test("concurrent");
      base_slices = slices_taken;
      out_ready   = 1'b1;
      repeat (stream_words)
      begin
         push_valid = 1'b1;
         push_data  = rand_word();
         repeat (slices_per_word)
         begin
            if (push_ready !== 1'b1)
               report_mismatch("push_ready", 64'(1'b1), 64'(push_ready));
            step_cycle();
            push_valid = 1'b0;
         end
      end
      wait_slices(base_slices + stream_words * slices_per_word);
      end_test();

      start_test("empty_drain");
      base_slices = slices_taken;
      repeat (20)
      begin
         if (out_valid !== 1'b0)
            report_mismatch("out_valid while empty", 64'(1'b0), 64'(out_valid));
         step_cycle();
      end
      push_valid = 1'b1;
      push_data  = rand_word();
      step_cycle();
      push_valid = 1'b0;
      while (!out_valid)
         step_cycle();
      wait_slices(base_slices + slices_per_word);
      step_cycle();
      if (out_valid !== 1'b0)
         report_mismatch("out_valid after drain", 64'(1'b0), 64'(out_valid));
      end_test();

      $display("tests run %0d, passed %0d, failed %0d, errors %0d",
               tests_passed + tests_failed, tests_passed, tests_failed, errors);
      if (tests_failed == 0 && errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

//--- fifo_45to5.f
src/fifo_pkg.sv
src/word_ram.sv
src/wide_fifo_ctrl.sv
src/slice_unpacker.sv
src/fifo_45to5.sv
sim/tb_fifo_45to5.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the fifo_45to5 testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module tb_fifo_45to5 \
   -Mdir obj_dir \
   -f fifo_45to5.f

run_status=0
output=$(./obj_dir/Vtb_fifo_45to5 2>&1) || run_status=$?
echo "$output"

if grep -qxF '>>> PASS' <<< "$output"; then
   echo "simulation passed"
   exit 0
fi

echo "simulation failed, exit status ${run_status}"
exit 1
